// File: hw/api_cfg_pkg.sv
`default_nettype none

package api_cfg_pkg;

	// Chain and word size
	localparam int API_NUM = 4;
	localparam int WORD_W = 32;

	// FIFO depths in words
	localparam int TX_DEPTH = 64;
	localparam int RX_DEPTH = 32;
	localparam int CNT_W = $clog2((TX_DEPTH > RX_DEPTH ? TX_DEPTH : RX_DEPTH) + 1);

	// Receive filtering within a channel
	localparam int WORK_LEN = 4; // Words per group
	localparam int RX_BLOCK_LEN = 3; // Words kept per group
	localparam logic [7:0] RX_TAG = 8'h12;

	// Free space needed before a channel may run
	localparam int RX_RESERVE = RX_BLOCK_LEN * API_NUM;

endpackage

`default_nettype wire

// File: hw/api_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module api_ctrl (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [27:0]                     timeout,
	input  logic [7:0]                      sck_div,
	input  logic [5:0]                      ch_num,
	input  logic [7:0]                      word_num,
	output api_types_pkg::seq_state_t       state,
	input  logic                            tx_valid,
	output logic                            tx_ready,
	input  logic [api_cfg_pkg::WORD_W-1:0]  tx_data,
	output logic                            rx_valid,
	output logic [api_cfg_pkg::WORD_W-1:0]  rx_data,
	input  logic [api_cfg_pkg::CNT_W-1:0]   rx_count,
	output logic [api_cfg_pkg::API_NUM-1:0] load,
	output logic                            sck,
	output logic                            mosi,
	input  logic [api_cfg_pkg::API_NUM-1:0] miso
);
	import api_cfg_pkg::*;
	import api_types_pkg::*;

	seq_state_t state_nxt;
	logic [5:0] ch_cnt;
	logic [7:0] word_cnt;
	logic [$clog2(WORK_LEN)-1:0] grp_cnt;
	logic [3:0] nop_cnt;
	logic send_req;
	logic strobe_done;
	logic room_ok;
	logic more_ch;
	logic nop_done;
	logic enter_work;
	logic enter_done;
	logic frame_start;
	logic timer_busy;
	logic phy_start;
	logic phy_done;
	logic [WORD_W-1:0] phy_tx;
	logic [WORD_W-1:0] phy_rx;
	logic miso_w;

	assign room_ok = (RX_DEPTH - int'(rx_count)) >= RX_RESERVE;
	assign more_ch = ch_cnt < ch_num;
	assign nop_done = nop_cnt == 4'd14; // 15 cycles of load settling
	assign enter_work = state != WORK && state_nxt == WORK;
	assign enter_done = state == NOP && state_nxt == DONE;
	assign frame_start = state == IDLE && state_nxt == WORK;

	always_comb begin
		state_nxt = state;
		case (state)
		IDLE: if (tx_valid && room_ok)
			state_nxt = WORK;
		WORK: if (word_cnt == word_num)
			state_nxt = NOP;
		NOP: if (nop_done) begin
			if (!more_ch)
				state_nxt = DONE;
			else if (tx_valid && room_ok) // Otherwise hold in NOP
				state_nxt = WORK;
		end
		DONE: if (strobe_done && !timer_busy)
			state_nxt = IDLE;
		default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ch_cnt <= '0;
			word_cnt <= '0;
			grp_cnt <= '0;
		end else if (enter_work) begin
			ch_cnt <= ch_cnt + 6'd1;
			word_cnt <= '0;
			grp_cnt <= '0;
		end else if (state == WORK && phy_done) begin
			word_cnt <= word_cnt + 8'd1;
			grp_cnt <= (grp_cnt == WORK_LEN - 1) ? '0 : grp_cnt + 1'b1;
		end else if (state == IDLE) begin
			ch_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || state != NOP)
			nop_cnt <= '0;
		else if (!nop_done)
			nop_cnt <= nop_cnt + 4'd1;
	end

	// Channel n selects chip n-1
	always_ff @(posedge clk) begin
		if (rst)
			load <= '1;
		else if (enter_work)
			load <= ~(API_NUM'(1) << ch_cnt);
		else if (enter_done)
			load <= '1;
	end

	// One word in flight at a time
	always_ff @(posedge clk) begin
		if (rst)
			send_req <= 1'b0;
		else if (enter_work || enter_done)
			send_req <= 1'b1;
		else if (state == WORK && phy_done && word_cnt + 8'd1 != word_num)
			send_req <= 1'b1;
		else if (phy_start)
			send_req <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst || state == IDLE)
			strobe_done <= 1'b0;
		else if (state == DONE && phy_done)
			strobe_done <= 1'b1;
	end

	assign phy_start = send_req && (state == DONE || (state == WORK && tx_valid));
	assign phy_tx = (state == DONE) ? '0 : tx_data; // Load strobe word is zero
	assign tx_ready = phy_start && state == WORK;

	assign rx_valid = state == WORK && phy_done && grp_cnt < RX_BLOCK_LEN;
	assign rx_data = (grp_cnt == RX_BLOCK_LEN - 1) ?
		{phy_rx[WORD_W-1:16], RX_TAG, 2'b00, ch_cnt} : phy_rx;

	assign miso_w = &(miso | load); // Deselected chips read as 1

	api_timer timer_i (
		.clk     (clk),
		.rst     (rst),
		.timeout (timeout),
		.start   (frame_start),
		.busy    (timer_busy)
	);

	api_phy phy_i (
		.clk     (clk),
		.rst     (rst),
		.div     (sck_div),
		.start   (phy_start),
		.tx_word (phy_tx),
		.done    (phy_done),
		.rx_word (phy_rx),
		.sck     (sck),
		.mosi    (mosi),
		.miso    (miso_w)
	);

	a_load_onehot: assert property (@(posedge clk) disable iff (rst)
		(state == WORK || state == NOP) |-> $onehot(~load));
	a_rx_room: assert property (@(posedge clk) disable iff (rst)
		rx_valid |-> rx_count < CNT_W'(RX_DEPTH));

endmodule

`default_nettype wire

// File: hw/api_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module api_fifo #(
	parameter int DEPTH = api_cfg_pkg::TX_DEPTH
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           in_valid,
	output logic                           in_ready,
	input  logic [api_cfg_pkg::WORD_W-1:0] in_data,
	output logic                           out_valid,
	input  logic                           out_ready,
	output logic [api_cfg_pkg::WORD_W-1:0] out_data,
	output logic [api_cfg_pkg::CNT_W-1:0]  count
);
	import api_cfg_pkg::*;

	localparam int AW = $clog2(DEPTH);

	logic [WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic push;
	logic pop;

	assign in_ready = count != CNT_W'(DEPTH);
	assign out_valid = count != '0;
	assign out_data = mem[rd_ptr]; // Head word falls through
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/api_phy.sv
`timescale 1ns/100ps
`default_nettype none

module api_phy (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [7:0]                     div,
	input  logic                           start,
	input  logic [api_cfg_pkg::WORD_W-1:0] tx_word,
	output logic                           done,
	output logic [api_cfg_pkg::WORD_W-1:0] rx_word,
	output logic                           sck,
	output logic                           mosi,
	input  logic                           miso
);
	import api_cfg_pkg::*;
	import api_types_pkg::*;

	phy_phase_t phase;
	logic [7:0] div_cnt;
	logic [$clog2(WORD_W)-1:0] bit_cnt;
	logic [WORD_W-1:0] tx_sh;
	logic [WORD_W-1:0] rx_sh;
	logic half_end;

	assign half_end = div_cnt == div; // div+1 cycles per half period

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= P_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
		end else begin
			case (phase)
			P_IDLE: if (start) begin
				phase <= P_LOW;
				div_cnt <= '0;
				bit_cnt <= '0;
				mosi <= tx_word[WORD_W-1]; // MSB first
			end
			P_LOW: if (half_end) begin
				div_cnt <= '0;
				sck <= 1'b1;
				phase <= P_HIGH;
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
			P_HIGH: if (half_end) begin
				div_cnt <= '0;
				sck <= 1'b0;
				if (bit_cnt == WORD_W - 1) begin
					phase <= P_END;
					mosi <= 1'b0;
				end else begin
					phase <= P_LOW;
					bit_cnt <= bit_cnt + 1'b1;
					mosi <= tx_sh[WORD_W-2]; // Next bit on falling edge
				end
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
			default: phase <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == P_IDLE && start)
			tx_sh <= tx_word;
		else if (phase == P_HIGH && half_end)
			tx_sh <= {tx_sh[WORD_W-2:0], 1'b0};
		if (phase == P_LOW && half_end)
			rx_sh <= {rx_sh[WORD_W-2:0], miso}; // Sample as sck rises
	end

	assign done = phase == P_END;
	assign rx_word = rx_sh;

	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> phase == P_IDLE);

endmodule

`default_nettype wire

// File: hw/api_timer.sv
`timescale 1ns/100ps
`default_nettype none

module api_timer (
	input  logic        clk,
	input  logic        rst,
	input  logic [27:0] timeout,
	input  logic        start,
	output logic        busy
);

	logic [27:0] cnt;

	always_ff @(posedge clk) begin
		if (rst)
			cnt <= '0;
		else if (start)
			cnt <= timeout; // Reload at frame start
		else if (cnt != '0)
			cnt <= cnt - 28'd1;
	end

	// High for exactly timeout cycles after start
	assign busy = cnt != '0;

endmodule

`default_nettype wire

// File: hw/api_top.sv
`timescale 1ns/100ps
`default_nettype none

module api_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            tx_valid,
	output logic                            tx_ready,
	input  logic [api_cfg_pkg::WORD_W-1:0]  tx_data,
	output logic                            rx_valid,
	input  logic                            rx_ready,
	output logic [api_cfg_pkg::WORD_W-1:0]  rx_data,
	input  logic [27:0]                     cfg_timeout,
	input  logic [7:0]                      cfg_sck,
	input  logic [5:0]                      cfg_ch_num,
	input  logic [7:0]                      cfg_word_num,
	output logic                            sck,
	output logic                            mosi,
	output logic [api_cfg_pkg::API_NUM-1:0] load,
	input  logic [api_cfg_pkg::API_NUM-1:0] miso,
	output api_types_pkg::seq_state_t       state
);
	import api_cfg_pkg::*;

	logic txq_valid;
	logic txq_ready;
	logic [WORD_W-1:0] txq_data;
	logic rxq_valid;
	logic [WORD_W-1:0] rxq_data;
	logic [CNT_W-1:0] rxq_count;

	api_fifo #(.DEPTH(TX_DEPTH)) tx_fifo_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (tx_valid),
		.in_ready  (tx_ready),
		.in_data   (tx_data),
		.out_valid (txq_valid),
		.out_ready (txq_ready),
		.out_data  (txq_data),
		.count     ()
	);

	// Room is checked through count, so in_ready stays open
	api_fifo #(.DEPTH(RX_DEPTH)) rx_fifo_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (rxq_valid),
		.in_ready  (),
		.in_data   (rxq_data),
		.out_valid (rx_valid),
		.out_ready (rx_ready),
		.out_data  (rx_data),
		.count     (rxq_count)
	);

	api_ctrl ctrl_i (
		.clk      (clk),
		.rst      (rst),
		.timeout  (cfg_timeout),
		.sck_div  (cfg_sck),
		.ch_num   (cfg_ch_num),
		.word_num (cfg_word_num),
		.state    (state),
		.tx_valid (txq_valid),
		.tx_ready (txq_ready),
		.tx_data  (txq_data),
		.rx_valid (rxq_valid),
		.rx_data  (rxq_data),
		.rx_count (rxq_count),
		.load     (load),
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso)
	);

endmodule

`default_nettype wire

// File: hw/api_types_pkg.sv
`default_nettype none

package api_types_pkg;

	// Frame sequencer states, also reported at the top level
	typedef enum logic [1:0] {IDLE, WORK, NOP, DONE} seq_state_t;

	// Serial engine phases
	typedef enum logic [1:0] {P_IDLE, P_LOW, P_HIGH, P_END} phy_phase_t;

endpackage

`default_nettype wire

// File: test/api_tb.sv
`timescale 1ns/100ps
`default_nettype none

module api_tb;
	import api_cfg_pkg::*;
	import api_types_pkg::*;

	localparam int NROWS = 4;
	localparam int HOLD = 100; // Idle cycles demanded of the stalled row

	int tbl_timeout [NROWS];
	int tbl_sck [NROWS];
	int tbl_ch [NROWS];
	int tbl_words [NROWS];
	bit tbl_stall [NROWS];

	int seed;
	longint limit;

	logic clk = 1'b0;
	logic rst;
	logic tx_valid;
	logic tx_ready;
	logic [WORD_W-1:0] tx_data;
	logic rx_valid;
	logic rx_ready;
	logic [WORD_W-1:0] rx_data;
	logic [27:0] cfg_timeout;
	logic [7:0] cfg_sck;
	logic [5:0] cfg_ch_num;
	logic [7:0] cfg_word_num;
	logic sck;
	logic mosi;
	logic [API_NUM-1:0] load;
	logic [API_NUM-1:0] miso;
	seq_state_t state;
	logic [4:0] bit_pos [API_NUM];

	api_top api_top_i (.*);

	always #4 clk = ~clk;

	// Selected chip flips each bit by the matching bit of its index byte
	always @(negedge sck) begin
		for (int i = 0; i < API_NUM; i++)
			if (!load[i])
				bit_pos[i] <= bit_pos[i] + 5'd1;
	end

	for (genvar i = 0; i < API_NUM; i++) begin : chip
		localparam logic [7:0] ID = i;
		assign miso[i] = load[i] | (mosi ^ ID[3'd7 - bit_pos[i][2:0]]); // Idle chips drive 1
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
	endtask

	function automatic longint budget_cycles();
		longint total;
		int word_t;
		int frame;
		total = 1000;
		for (int r = 0; r < NROWS; r++) begin
			word_t = 64 * (tbl_sck[r] + 1) + 3;
			frame = tbl_ch[r] * (tbl_words[r] * word_t + 20) + word_t + 5;
			if (frame < tbl_timeout[r] + 5)
				frame = tbl_timeout[r] + 5;
			total += (tbl_stall[r] ? 2 * frame + HOLD + 64 : frame);
		end
		return 2 * total;
	endfunction

	task automatic watchdog(input longint cycles);
		repeat (cycles) @(posedge clk);
		stop_run($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
	endtask

	task automatic run_row(input int r);
		logic [WORD_W-1:0] words [$];
		logic [WORD_W-1:0] exp_q [$];
		logic [WORD_W-1:0] echo;
		int frames;
		int pushed;
		int frames_done;
		int busy_cycles;
		int hold_cnt;
		frames = tbl_stall[r] ? 2 : 1; // Second frame must wait for a drain
		pushed = 0;
		frames_done = 0;
		busy_cycles = 0;
		hold_cnt = 0;
		cfg_timeout = 28'(tbl_timeout[r]);
		cfg_sck = 8'(tbl_sck[r]);
		cfg_ch_num = 6'(tbl_ch[r]);
		cfg_word_num = 8'(tbl_words[r]);
		for (int f = 0; f < frames; f++)
			for (int c = 1; c <= tbl_ch[r]; c++)
				for (int w = 0; w < tbl_words[r]; w++) begin
					words.push_back($random(seed));
					echo = words[$] ^ {4{8'(c - 1)}};
					if (w % WORK_LEN == RX_BLOCK_LEN - 1)
						exp_q.push_back({echo[31:16], RX_TAG, 8'(c)}); // Last kept word
					else if (w % WORK_LEN < RX_BLOCK_LEN)
						exp_q.push_back(echo);
				end
		while (pushed < words.size() || exp_q.size() != 0 || frames_done < frames) begin
			@(posedge clk);
			#1;
			if (state != IDLE) begin
				busy_cycles++;
			end else if (busy_cycles != 0) begin
				check(busy_cycles >= tbl_timeout[r], 1, "frame_cycles_ge_timeout");
				frames_done++;
				busy_cycles = 0;
			end
			if (tbl_stall[r] && frames_done == 1 && hold_cnt < HOLD) begin
				check(state, IDLE, "state");
				hold_cnt++;
			end
			tx_valid = pushed < words.size();
			tx_data = tx_valid ? words[pushed] : '0;
			rx_ready = !(tbl_stall[r] && (frames_done == 0 || hold_cnt < HOLD));
			if (tx_valid && tx_ready)
				pushed++;
			if (rx_valid && rx_ready) begin
				if (exp_q.size() == 0)
					stop_run("Receive FIFO returned a word when none was expected");
				check(rx_data, exp_q.pop_front(), "rx_data");
			end
		end
	endtask

	initial begin
		seed = 23825;
		// timeout, sck divider, channels, words, stall
		tbl_timeout = '{10, 10, 3000, 10};
		tbl_sck = '{1, 0, 0, 0};
		tbl_ch = '{1, 4, 1, 4};
		tbl_words = '{8, 4, 2, 8};
		tbl_stall = '{0, 0, 0, 1};
		rst = 1'b1;
		tx_valid = 1'b0;
		tx_data = '0;
		rx_ready = 1'b0;
		cfg_timeout = 28'(tbl_timeout[0]);
		cfg_sck = 8'(tbl_sck[0]);
		cfg_ch_num = 6'(tbl_ch[0]);
		cfg_word_num = 8'(tbl_words[0]);
		for (int i = 0; i < API_NUM; i++)
			bit_pos[i] = '0;
		limit = budget_cycles();
		fork
			watchdog(limit);
		join_none
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		check(load, {API_NUM{1'b1}}, "load");
		check(state, IDLE, "state");
		check(rx_valid, 1'b0, "rx_valid");
		check(sck, 1'b0, "sck");
		check(mosi, 1'b0, "mosi");
		check(tx_ready, 1'b1, "tx_ready");
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hw/api_cfg_pkg.sv
hw/api_types_pkg.sv
hw/api_fifo.sv
hw/api_timer.sv
hw/api_phy.sv
hw/api_ctrl.sv
hw/api_top.sv
test/api_tb.sv
